// ==== Bender.yml ====
package:
  name: ising_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ising_pkg.sv
      - hdl/ising_l1_mem.sv
      - hdl/ising_core_regs.sv
      - hdl/ising_anneal_engine.sv
      - hdl/ising_core_wrap.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/ising_core_assertions.sv
      - testbench/ising_core_tb.sv

// ==== hdl/ising_anneal_engine.sv ====
// Anneal engine: streams J rows, forms local fields and energy, updates spins, records each pass

`default_nettype none

`include "ising_settings.svh"

module ising_anneal_engine (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  ising_pkg::spin_vec_t spin_init_i,
    input  ising_pkg::iter_t     iter_num_i,
    output ising_pkg::mem_req_t  j_req_o,
    input  ising_pkg::j_row_t    j_rdata_i,
    output ising_pkg::mem_req_t  flip_req_o,
    output logic                 busy_o,
    output logic                 done_o,
    output ising_pkg::energy_t   energy_o,
    output ising_pkg::spin_vec_t spin_o
);

    localparam int ROW_BIT = $clog2(`ISING_NUM_SPIN);

    ising_pkg::engine_state_e state_q;
    logic [ROW_BIT-1:0]       row_q;
    logic [ROW_BIT-1:0]       rd_row_q;
    logic                     rd_valid_q;
    ising_pkg::iter_t         iter_q;
    ising_pkg::iter_t         iter_tot_q;
    ising_pkg::spin_vec_t     spin_q;
    ising_pkg::spin_vec_t     spin_nxt_q;
    ising_pkg::energy_t       acc_q;
    ising_pkg::energy_t       energy_q;
    logic                     done_q;
    ising_pkg::field_t        field;
    ising_pkg::energy_t       term;
    logic                     launch;
    logic                     clr_acc;

    assign launch  = (state_q == ising_pkg::IDLE) & start_i;
    assign clr_acc = launch | (state_q == ising_pkg::RECORD);

    //////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ising_pkg::IDLE;
            row_q      <= '0;
            iter_q     <= '0;
            iter_tot_q <= '0;
            spin_q     <= '0;
            energy_q   <= '0;
            done_q     <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            done_q     <= 1'b0;
            rd_valid_q <= (state_q == ising_pkg::READ);
            case (state_q)
                ising_pkg::IDLE: begin
                    if (start_i) begin
                        state_q    <= ising_pkg::READ;
                        row_q      <= '0;
                        iter_q     <= '0;
                        spin_q     <= spin_init_i;
                        // Zero iterations run once
                        iter_tot_q <= (iter_num_i == '0) ? ising_pkg::iter_t'(1) : iter_num_i;
                    end
                end
                ising_pkg::READ: begin
                    row_q <= row_q + 1'b1;
                    if (row_q == ROW_BIT'(`ISING_NUM_SPIN - 1)) begin
                        state_q <= ising_pkg::DRAIN;
                    end
                end
                ising_pkg::DRAIN: begin
                    state_q <= ising_pkg::RECORD;
                end
                ising_pkg::RECORD: begin
                    spin_q   <= spin_nxt_q;
                    energy_q <= acc_q;
                    row_q    <= '0;
                    if (iter_q == iter_tot_q - 1'b1) begin
                        state_q <= ising_pkg::IDLE;
                        done_q  <= 1'b1;
                    end else begin
                        iter_q  <= iter_q + 1'b1;
                        state_q <= ising_pkg::READ;
                    end
                end
                default: state_q <= ising_pkg::IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Field and energy datapath
    //////////////////////////////////////////////////
    // h_i from the returning row, spin bit 0 counts as -1
    always_comb begin
        ising_pkg::field_t coup;
        field = '0;
        coup  = '0;
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            coup = $signed(j_rdata_i[j]);
            if (spin_q[j]) begin
                field = field + coup;
            end else begin
                field = field - coup;
            end
        end
        term = field;
    end

    always_ff @(posedge clk_i) begin
        rd_row_q <= row_q;
        if (rd_valid_q) begin
            // Zero field keeps the old spin
            if (field == '0) begin
                spin_nxt_q[rd_row_q] <= spin_q[rd_row_q];
            end else begin
                spin_nxt_q[rd_row_q] <= ~field[`ISING_FIELD_BIT-1];
            end
            // E -= s_i * h_i
            acc_q <= spin_q[rd_row_q] ? (acc_q - term) : (acc_q + term);
        end else if (clr_acc) begin
            acc_q <= '0;
        end
    end

    //////////////////////////////////////////////////
    // Memory requests
    //////////////////////////////////////////////////
    always_comb begin
        j_req_o       = '0;
        j_req_o.valid = (state_q == ising_pkg::READ);
        j_req_o.write = 1'b0;
        j_req_o.addr  = `ISING_ADDR_BIT'(row_q);

        flip_req_o       = '0;
        flip_req_o.valid = (state_q == ising_pkg::RECORD);
        flip_req_o.write = 1'b1;
        flip_req_o.addr  = `ISING_ADDR_BIT'(iter_q);
        flip_req_o.wdata = `ISING_DATA_BIT'(spin_nxt_q);
    end

    assign busy_o   = (state_q != ising_pkg::IDLE);
    assign done_o   = done_q;
    assign energy_o = energy_q;
    assign spin_o   = spin_q;

endmodule

`default_nettype wire

// ==== hdl/ising_core_regs.sv ====
// Host register block of the Ising core: start command, run configuration and status readback

`default_nettype none

`include "ising_settings.svh"

module ising_core_regs (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  ising_pkg::reg_req_t  reg_req_i,
    output ising_pkg::reg_rsp_t  reg_rsp_o,
    output logic                 start_o,
    output ising_pkg::spin_vec_t spin_init_o,
    output ising_pkg::iter_t     iter_num_o,
    input  logic                 busy_i,
    input  logic                 done_i,
    input  ising_pkg::energy_t   energy_i,
    input  ising_pkg::spin_vec_t spin_i
);

    localparam int DW = `ISING_DATA_BIT;
    localparam int EW = `ISING_ENERGY_BIT;

    ising_pkg::spin_vec_t spin_init_q;
    ising_pkg::iter_t     iter_num_q;
    logic                 start_q;
    logic                 done_q;
    logic                 rvalid_q;
    logic [DW-1:0]        rdata_q;
    logic [DW-1:0]        rdata_mux;
    logic                 wr_en;
    logic                 rd_en;

    assign wr_en = reg_req_i.valid & reg_req_i.write;
    assign rd_en = reg_req_i.valid & ~reg_req_i.write;

    //////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spin_init_q <= '0;
            iter_num_q  <= '0;
            start_q     <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            start_q <= wr_en & (reg_req_i.addr == ising_pkg::CTRL) & reg_req_i.wdata[0];
            if (wr_en && reg_req_i.addr == ising_pkg::SPIN_INIT) begin
                spin_init_q <= reg_req_i.wdata[`ISING_NUM_SPIN-1:0];
            end
            if (wr_en && reg_req_i.addr == ising_pkg::ITER_NUM) begin
                iter_num_q <= reg_req_i.wdata[$bits(ising_pkg::iter_t)-1:0];
            end
            // Sticky done, a new start wins over a late done
            if (start_q) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////
    always_comb begin
        rdata_mux = '0;
        case (reg_req_i.addr)
            ising_pkg::SPIN_INIT:  rdata_mux[`ISING_NUM_SPIN-1:0] = spin_init_q;
            ising_pkg::ITER_NUM:   rdata_mux[$bits(ising_pkg::iter_t)-1:0] = iter_num_q;
            ising_pkg::STATUS:     rdata_mux[1:0] = {done_q, busy_i};
            ising_pkg::ENERGY:     rdata_mux = {{(DW-EW){energy_i[EW-1]}}, energy_i};
            ising_pkg::SPIN_STATE: rdata_mux[`ISING_NUM_SPIN-1:0] = spin_i;
            default:               rdata_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rdata_mux;
        end
    end

    assign reg_rsp_o.rvalid = rvalid_q;
    assign reg_rsp_o.rdata  = rdata_q;

    assign start_o     = start_q;
    assign spin_init_o = spin_init_q;
    assign iter_num_o  = iter_num_q;

endmodule

`default_nettype wire

// ==== hdl/ising_core_wrap.sv ====
// Top level of the Ising core, joining registers, anneal engine and the two L1 memories

`default_nettype none

`include "ising_settings.svh"

module ising_core_wrap (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  ising_pkg::reg_req_t reg_req_i,
    output ising_pkg::reg_rsp_t reg_rsp_o,
    input  ising_pkg::mem_req_t j_host_req_i,
    input  ising_pkg::mem_req_t flip_host_req_i,
    output ising_pkg::mem_rsp_t j_host_rsp_o,
    output ising_pkg::mem_rsp_t flip_host_rsp_o,
    output logic                done_o
);

    logic                 start;
    logic                 busy;
    logic                 done;
    logic                 host_own_q;
    ising_pkg::spin_vec_t spin_init;
    ising_pkg::iter_t     iter_num;
    ising_pkg::energy_t   energy;
    ising_pkg::spin_vec_t spin;
    ising_pkg::mem_req_t  eng_j_req;
    ising_pkg::mem_req_t  eng_flip_req;
    ising_pkg::mem_req_t  j_mem_req;
    ising_pkg::mem_req_t  flip_mem_req;
    ising_pkg::mem_rsp_t  j_mem_rsp;
    ising_pkg::mem_rsp_t  flip_mem_rsp;

    // Responses reach the host only for requests it owned
    function automatic ising_pkg::mem_rsp_t host_rsp(ising_pkg::mem_rsp_t rsp, logic own);
        ising_pkg::mem_rsp_t r;
        r        = rsp;
        r.rvalid = rsp.rvalid & own;
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Register block and engine
    //////////////////////////////////////////////////
    ising_core_regs u_core_regs (
        .clk_i       (clk_i      ),
        .arst_n_i    (arst_n_i   ),
        .reg_req_i   (reg_req_i  ),
        .reg_rsp_o   (reg_rsp_o  ),
        .start_o     (start      ),
        .spin_init_o (spin_init  ),
        .iter_num_o  (iter_num   ),
        .busy_i      (busy       ),
        .done_i      (done       ),
        .energy_i    (energy     ),
        .spin_i      (spin       )
    );

    ising_anneal_engine u_anneal_engine (
        .clk_i       (clk_i                                 ),
        .arst_n_i    (arst_n_i                              ),
        .start_i     (start                                 ),
        .spin_init_i (spin_init                             ),
        .iter_num_i  (iter_num                              ),
        .j_req_o     (eng_j_req                             ),
        .j_rdata_i   (ising_pkg::j_row_t'(j_mem_rsp.rdata)  ),
        .flip_req_o  (eng_flip_req                          ),
        .busy_o      (busy                                  ),
        .done_o      (done                                  ),
        .energy_o    (energy                                ),
        .spin_o      (spin                                  )
    );

    //////////////////////////////////////////////////
    // Memory mux, engine owns both while busy
    //////////////////////////////////////////////////
    assign j_mem_req    = busy ? eng_j_req : j_host_req_i;
    assign flip_mem_req = busy ? eng_flip_req : flip_host_req_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            host_own_q <= 1'b0;
        end else begin
            host_own_q <= ~busy;
        end
    end

    assign j_host_rsp_o    = host_rsp(j_mem_rsp, host_own_q);
    assign flip_host_rsp_o = host_rsp(flip_mem_rsp, host_own_q);

    ising_l1_mem #(
        .WIDTH (`ISING_DATA_BIT),
        .DEPTH (`ISING_NUM_SPIN)
    ) u_l1_mem_j (
        .clk_i    (clk_i    ),
        .arst_n_i (arst_n_i ),
        .req_i    (j_mem_req),
        .rsp_o    (j_mem_rsp)
    );

    ising_l1_mem #(
        .WIDTH (`ISING_NUM_SPIN  ),
        .DEPTH (`ISING_FLIP_DEPTH)
    ) u_l1_mem_flip (
        .clk_i    (clk_i       ),
        .arst_n_i (arst_n_i    ),
        .req_i    (flip_mem_req),
        .rsp_o    (flip_mem_rsp)
    );

    assign done_o = done;

endmodule

`default_nettype wire

// ==== hdl/ising_l1_mem.sv ====
// Single-port L1 RAM with one-cycle read latency, instantiated for the J and flip memories

`default_nettype none

module ising_l1_mem #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  ising_pkg::mem_req_t  req_i,
    output ising_pkg::mem_rsp_t  rsp_o
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [WIDTH-1:0] rdata_q;
    logic             rvalid_q;
    logic [AW-1:0]    idx;

    // Upper address bits are ignored
    assign idx = req_i.addr[AW-1:0];

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            if (req_i.write) begin
                mem[idx] <= req_i.wdata[WIDTH-1:0];
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    // Only reads get a response
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.valid & ~req_i.write;
        end
    end

    always_comb begin
        rsp_o                   = '0;
        rsp_o.rvalid            = rvalid_q;
        rsp_o.rdata[WIDTH-1:0]  = rdata_q;
    end

endmodule

`default_nettype wire

// ==== hdl/ising_pkg.sv ====
// Shared types of the Ising core, referenced with scoped names by all RTL and testbench files

`default_nettype none

`include "ising_settings.svh"

package ising_pkg;

    //////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////
    typedef logic [`ISING_NUM_SPIN-1:0] spin_vec_t;

    // One J row, entry j couples spin j into the row's field
    typedef logic signed [`ISING_NUM_SPIN-1:0][`ISING_BIT_J-1:0] j_row_t;

    typedef logic signed [`ISING_FIELD_BIT-1:0] field_t;
    typedef logic signed [`ISING_ENERGY_BIT-1:0] energy_t;

    // Iteration index and count, wide enough to hold FLIP_DEPTH itself
    typedef logic [$clog2(`ISING_FLIP_DEPTH):0] iter_t;

    //////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                       valid;
        logic                       write;
        logic [`ISING_ADDR_BIT-1:0] addr;
        logic [`ISING_DATA_BIT-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                       rvalid;
        logic [`ISING_DATA_BIT-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                       valid;
        logic                       write;
        logic [`ISING_ADDR_BIT-1:0] addr;
        logic [`ISING_DATA_BIT-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                       rvalid;
        logic [`ISING_DATA_BIT-1:0] rdata;
    } reg_rsp_t;

    //////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN,
        RECORD
    } engine_state_e;

    typedef enum logic [`ISING_ADDR_BIT-1:0] {
        CTRL       = 0,
        SPIN_INIT  = 1,
        ITER_NUM   = 2,
        STATUS     = 3,
        ENERGY     = 4,
        SPIN_STATE = 5
    } reg_addr_e;

endpackage

`default_nettype wire

// ==== hdl/ising_settings.svh ====
// Sizing macros of the Ising core, included by the package and by every RTL file using them

`ifndef ISING_SETTINGS_SVH
`define ISING_SETTINGS_SVH

// Spin array
`define ISING_NUM_SPIN 8

// Signed coupling width, one J entry
`define ISING_BIT_J 4

// Signed local field width
`define ISING_FIELD_BIT 8

// Signed energy accumulator width
`define ISING_ENERGY_BIT 16

// Flip memory words, also the largest iteration count
`define ISING_FLIP_DEPTH 16

// Host side buses
`define ISING_ADDR_BIT 8
`define ISING_DATA_BIT 32

`endif

// ==== src.f ====
+incdir+hdl
hdl/ising_pkg.sv
hdl/ising_l1_mem.sv
hdl/ising_core_regs.sv
hdl/ising_anneal_engine.sv
hdl/ising_core_wrap.sv
testbench/ising_core_assertions.sv
testbench/ising_core_tb.sv

// ==== testbench/ising_core_assertions.sv ====
// Concurrent checks on the anneal engine handshake and requests, bound into the engine below

`default_nettype none

module ising_anneal_assertions (
    input logic                clk_i,
    input logic                arst_n_i,
    input logic                busy_i,
    input logic                done_i,
    input ising_pkg::mem_req_t j_req_i,
    input ising_pkg::mem_req_t flip_req_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        done_i |=> !done_i)
        else $error("done_o stayed high for more than one cycle");

    // J memory is read-only for the engine
    a_j_read_only: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(j_req_i.valid && j_req_i.write))
        else $error("engine issued a write on the J memory port");

    a_flip_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        flip_req_i.valid |-> busy_i)
        else $error("flip memory request outside of a run");

    a_done_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        done_i |-> !busy_i)
        else $error("done_o raised while the engine is busy");

endmodule

bind ising_anneal_engine ising_anneal_assertions u_anneal_assertions (
    .clk_i      (clk_i     ),
    .arst_n_i   (arst_n_i  ),
    .busy_i     (busy_o    ),
    .done_i     (done_o    ),
    .j_req_i    (j_req_o   ),
    .flip_req_i (flip_req_o)
);

`default_nettype wire

// ==== testbench/ising_core_stim.txt ====
// Line 3 is the case count; each case: spin_init iter_num energy final_spins (hex),
// then the 8 J rows (hex nibble j of row i is signed J[i][j]) and one flip word per iteration
2
a5 3 0010 3a
d0010020
00300f02
000040f0
010e0400
0010e001
0c010030
20c01000
8200000d
3a a7 3a
ff 2 ffe8 bf
d0010020
00300f02
000040f0
010e0400
0010e001
0c010030
20c01000
8200000d
3f bf

// ==== testbench/ising_core_tb.sv ====
// Self-checking testbench of the Ising core, run from src.f with the case file under testbench/

`default_nettype none

`include "ising_settings.svh"

module ising_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NS        = `ISING_NUM_SPIN;
    localparam int AW        = `ISING_ADDR_BIT;
    localparam int DW        = `ISING_DATA_BIT;
    localparam int EW        = `ISING_ENERGY_BIT;
    localparam int MAX_CASES = 4;
    localparam int CLK_NS    = 10;

    logic                clk;
    logic                arst_n;
    ising_pkg::reg_req_t reg_req;
    ising_pkg::reg_rsp_t reg_rsp;
    ising_pkg::mem_req_t j_host_req;
    ising_pkg::mem_req_t flip_host_req;
    ising_pkg::mem_rsp_t j_host_rsp;
    ising_pkg::mem_rsp_t flip_host_rsp;
    logic                done;

    // Test cases as read from the file
    int                   n_cases;
    ising_pkg::spin_vec_t case_spin_init [MAX_CASES];
    logic [DW-1:0]        case_iter      [MAX_CASES];
    ising_pkg::energy_t   case_energy    [MAX_CASES];
    ising_pkg::spin_vec_t case_spin      [MAX_CASES];
    logic [DW-1:0]        case_j         [MAX_CASES][NS];
    ising_pkg::spin_vec_t case_flip      [MAX_CASES][`ISING_FLIP_DEPTH];

    int value_errors;
    int proto_errors;
    int limit_ns;

    ising_core_wrap UUT (
        .clk_i           (clk          ),
        .arst_n_i        (arst_n       ),
        .reg_req_i       (reg_req      ),
        .reg_rsp_o       (reg_rsp      ),
        .j_host_req_i    (j_host_req   ),
        .flip_host_req_i (flip_host_req),
        .j_host_rsp_o    (j_host_rsp   ),
        .flip_host_rsp_o (flip_host_rsp),
        .done_o          (done         )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Hard limit on the run time
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_word(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_energy(input string name, input ising_pkg::energy_t exp,
                                input ising_pkg::energy_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error: %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_spins(input string name, input ising_pkg::spin_vec_t exp,
                               input ising_pkg::spin_vec_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////
    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic reg_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        reg_req.valid = 1'b1;
        reg_req.write = 1'b1;
        reg_req.addr  = addr;
        reg_req.wdata = data;
        next_cycle();
        reg_req = '0;
    endtask

    task automatic reg_read(input logic [AW-1:0] addr, output logic [DW-1:0] data);
        reg_req.valid = 1'b1;
        reg_req.write = 1'b0;
        reg_req.addr  = addr;
        reg_req.wdata = '0;
        next_cycle();
        reg_req = '0;
        data    = reg_rsp.rdata;
        if (reg_rsp.rvalid !== 1'b1) begin
            proto_errors++;
            $display("Register read of address %0d got no rvalid one cycle later", addr);
        end
        next_cycle();
        if (reg_rsp.rvalid !== 1'b0) begin
            proto_errors++;
            $display("Register rvalid stayed high for more than one cycle");
        end
    endtask

    task automatic j_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        j_host_req.valid = 1'b1;
        j_host_req.write = 1'b1;
        j_host_req.addr  = addr;
        j_host_req.wdata = data;
        next_cycle();
        j_host_req = '0;
    endtask

    task automatic host_mem_read(input logic sel_flip, input logic [AW-1:0] addr,
                                 output logic [DW-1:0] data);
        ising_pkg::mem_req_t req;
        ising_pkg::mem_rsp_t rsp;
        req       = '0;
        req.valid = 1'b1;
        req.addr  = addr;
        if (sel_flip) begin
            flip_host_req = req;
        end else begin
            j_host_req = req;
        end
        next_cycle();
        j_host_req    = '0;
        flip_host_req = '0;
        rsp  = sel_flip ? flip_host_rsp : j_host_rsp;
        data = rsp.rdata;
        if (rsp.rvalid !== 1'b1) begin
            proto_errors++;
            $display("%s memory read of address %0d got no rvalid one cycle later",
                     sel_flip ? "Flip" : "J", addr);
        end
        next_cycle();
        rsp = sel_flip ? flip_host_rsp : j_host_rsp;
        if (rsp.rvalid !== 1'b0) begin
            proto_errors++;
            $display("Memory rvalid stayed high for more than one cycle");
        end
    endtask

    task automatic wait_done(input int max_cycles);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < max_cycles) begin
            next_cycle();
            cycles++;
        end
        if (done !== 1'b1) begin
            proto_errors++;
            $display("done_o did not pulse within %0d cycles of the start", max_cycles);
        end
    endtask

    //////////////////////////////////////////////////
    // Case file and case sequence
    //////////////////////////////////////////////////
    task automatic read_case_file(output bit ok);
        int            fd;
        int            cnt;
        int            eff;
        string         line;
        logic [DW-1:0] w0;
        logic [DW-1:0] w1;
        logic [DW-1:0] w2;
        logic [DW-1:0] w3;
        ok = 1'b0;
        fd = $fopen("testbench/ising_core_stim.txt", "r");
        if (fd == 0) begin
            return;
        end
        // Two header lines describe the columns
        cnt = $fgets(line, fd);
        cnt = $fgets(line, fd);
        cnt = $fscanf(fd, "%d", n_cases);
        if (cnt != 1 || n_cases < 1 || n_cases > MAX_CASES) begin
            $fclose(fd);
            return;
        end
        ok = 1'b1;
        for (int c = 0; c < n_cases; c++) begin
            cnt = $fscanf(fd, "%h %h %h %h", w0, w1, w2, w3);
            if (cnt != 4) begin
                ok = 1'b0;
            end
            case_spin_init[c] = w0[NS-1:0];
            case_iter[c]      = w1;
            case_energy[c]    = w2[EW-1:0];
            case_spin[c]      = w3[NS-1:0];
            for (int r = 0; r < NS; r++) begin
                cnt = $fscanf(fd, "%h", w0);
                if (cnt != 1) begin
                    ok = 1'b0;
                end
                case_j[c][r] = w0;
            end
            eff = (w1 == 0) ? 1 : int'(w1);
            if (eff > `ISING_FLIP_DEPTH) begin
                ok  = 1'b0;
                eff = `ISING_FLIP_DEPTH;
            end
            for (int k = 0; k < eff; k++) begin
                cnt = $fscanf(fd, "%h", w0);
                if (cnt != 1) begin
                    ok = 1'b0;
                end
                case_flip[c][k] = w0[NS-1:0];
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int c);
        logic [DW-1:0] rd;
        int            eff;
        string         tag;
        eff = (case_iter[c] == 0) ? 1 : int'(case_iter[c]);
        tag = $sformatf("case %0d", c);

        reg_write(ising_pkg::SPIN_INIT, DW'(case_spin_init[c]));
        reg_write(ising_pkg::ITER_NUM, case_iter[c]);
        reg_read(ising_pkg::SPIN_INIT, rd);
        check_word({tag, " SPIN_INIT readback"}, DW'(case_spin_init[c]), rd);
        reg_read(ising_pkg::ITER_NUM, rd);
        check_word({tag, " ITER_NUM readback"}, case_iter[c], rd);
        // Registers now hold non-zero values
        reg_read(AW'(8'h2a), rd);
        check_word({tag, " unmapped register"}, '0, rd);

        for (int r = 0; r < NS; r++) begin
            j_write(AW'(r), case_j[c][r]);
        end
        for (int r = 0; r < NS; r++) begin
            host_mem_read(1'b0, AW'(r), rd);
            check_word($sformatf("%s J row %0d", tag, r), case_j[c][r], rd);
        end

        // Busy set and done flag cleared once start has reached the engine
        reg_write(ising_pkg::CTRL, DW'(1));
        next_cycle();
        reg_read(ising_pkg::STATUS, rd);
        check_word({tag, " STATUS while busy"}, DW'(1), rd);

        wait_done(eff * (NS + 2) + 20);
        next_cycle();
        reg_read(ising_pkg::STATUS, rd);
        check_word({tag, " STATUS after done"}, DW'(2), rd);
        reg_read(ising_pkg::ENERGY, rd);
        check_energy({tag, " ENERGY"}, case_energy[c], rd[EW-1:0]);
        check_word({tag, " ENERGY word"},
                   {{(DW-EW){case_energy[c][EW-1]}}, case_energy[c]}, rd);
        reg_read(ising_pkg::SPIN_STATE, rd);
        check_spins({tag, " SPIN_STATE"}, case_spin[c], rd[NS-1:0]);

        for (int k = 0; k < eff; k++) begin
            host_mem_read(1'b1, AW'(k), rd);
            check_word($sformatf("%s flip word %0d", tag, k), DW'(case_flip[c][k]), rd);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        bit            ok;
        int            eff;
        logic [DW-1:0] rd;
        reg_req       = '0;
        j_host_req    = '0;
        flip_host_req = '0;
        arst_n        = 1'b0;
        value_errors  = 0;
        proto_errors  = 0;
        limit_ns      = 0;

        read_case_file(ok);
        if (!ok) begin
            proto_errors++;
            $display("Case file testbench/ising_core_stim.txt is missing or malformed");
        end else begin
            limit_ns = 2000;
            for (int c = 0; c < n_cases; c++) begin
                eff      = (case_iter[c] == 0) ? 1 : int'(case_iter[c]);
                limit_ns = limit_ns + eff * (NS + 2) * CLK_NS * 4;
            end
        end

        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        next_cycle();

        if (done !== 1'b0) begin
            proto_errors++;
            $display("done_o is high after reset");
        end
        reg_read(ising_pkg::STATUS, rd);
        check_word("STATUS after reset", '0, rd);
        reg_read(AW'(8'h2a), rd);
        check_word("unmapped register", '0, rd);

        if (ok) begin
            for (int c = 0; c < n_cases; c++) begin
                run_case(c);
            end
        end

        $display("Summary: %0d value errors, %0d protocol errors", value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
